// ==== src/tester_config.svh ====
`ifndef TESTER_CONFIG_SVH
`define TESTER_CONFIG_SVH

// Register bus geometry
`define TESTER_DATA_BITS 8
`define TESTER_ADDR_BITS 14
`define TESTER_OFFSET_BITS 12

// Board resources
`define TESTER_ANALOG_COUNT 4
`define TESTER_SAMPLE_BITS 12
`define TESTER_DIGITAL_ID_COUNT 3

`define TESTER_VERSION 32'h0000_0001

// Values reported in the configuration-info bytes
`define TESTER_IO_PHYSICAL 16
`define TESTER_IO_LOGICAL_PER_BANK 8
`define TESTER_IO_BANKS 2

`endif

// ==== src/tester_regs_pkg.sv ====
`default_nettype none

`include "tester_config.svh"

package tester_regs_pkg;

    typedef logic [`TESTER_DATA_BITS-1:0] data_t;
    typedef logic [`TESTER_ADDR_BITS-1:0] addr_t;
    typedef logic [`TESTER_OFFSET_BITS-1:0] offset_t;

    // Top two address bits pick the block, other codes are unmapped
    typedef enum logic [1:0] {
        BLK_CONTROL = 2'd0,
        BLK_SYS     = 2'd2
    } blk_sel_e;

    typedef enum logic [`TESTER_OFFSET_BITS-1:0] {
        CTRL_ID0  = 12'h000,
        CTRL_ID1  = 12'h001,
        CTRL_ID2  = 12'h002,
        CTRL_ID3  = 12'h003,
        CTRL_VER0 = 12'h010,
        CTRL_HWID = 12'h014,
        CTRL_INFO = 12'h020
    } ctrl_reg_e;

    // Reset register is write-only and sits under the first ID byte
    localparam ctrl_reg_e CTRL_RESET = CTRL_ID0;

    typedef enum logic [`TESTER_OFFSET_BITS-1:0] {
        SYS_PWM_EN     = 12'hC01,
        SYS_PWM_PERIOD = 12'hC02,
        SYS_PWM_HIGH   = 12'hC06,
        SYS_MUX_MEAS   = 12'hC0A,
        SYS_SAMPLES    = 12'hC0C,
        SYS_CYCLES     = 12'hC10,
        SYS_SNAPSHOT   = 12'hC18,
        SYS_SAMPLE_ADC = 12'hC19,
        SYS_ANIN_BASE  = 12'hC30
    } sys_reg_e;

endpackage

`default_nettype wire

// ==== src/tester_meas_pkg.sv ====
`default_nettype none

package tester_meas_pkg;

    // ADC results are kept zero-extended to 16 bits
    typedef logic [15:0] meas_t;
    typedef logic [63:0] sum_t;

    typedef logic [31:0] samples_t;
    typedef logic [63:0] cycles_t;

    typedef logic [31:0] pwm_word_t;

endpackage

`default_nettype wire

// ==== src/apb_block_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_block_decode
    import tester_regs_pkg::*;
(
    input  logic     i_psel,
    input  blk_sel_e i_blk,
    input  data_t    i_ctrl_prdata,
    input  data_t    i_sys_prdata,
    output logic     o_ctrl_sel,
    output logic     o_sys_sel,
    output data_t    o_prdata
);

    assign o_ctrl_sel = i_psel && (i_blk == BLK_CONTROL);
    assign o_sys_sel = i_psel && (i_blk == BLK_SYS);

    // Slaves register their read byte, the address is stable over the access cycle
    always_comb begin
        case (i_blk)
            BLK_CONTROL: o_prdata = i_ctrl_prdata;
            BLK_SYS:     o_prdata = i_sys_prdata;
            default:     o_prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/tester_control_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tester_config.svh"

module tester_control_regs
    import tester_regs_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    i_sel,
    input  logic    i_penable,
    input  logic    i_pwrite,
    input  offset_t i_offset,
    input  data_t   i_pwdata,
    input  logic    i_reset_btn_n,
    input  logic [`TESTER_DIGITAL_ID_COUNT-1:0] i_digital_id,
    output data_t   o_prdata,
    output logic    o_reset_req,
    output logic    o_reprogram_req,
    output logic    o_reset_peripherals
);

    localparam logic [31:0] VERSION_WORD = `TESTER_VERSION;
    localparam int DB = `TESTER_DATA_BITS;

    logic reset_req_q;
    data_t rd_next;

    // Button is active low and requests a reset on its own
    assign o_reset_req = reset_req_q || !i_reset_btn_n;

    always_comb begin
        case (i_offset)
            CTRL_ID0:      rd_next = "m";
            CTRL_ID1:      rd_next = "b";
            CTRL_ID2:      rd_next = "e";
            CTRL_ID3:      rd_next = "d";
            CTRL_VER0:     rd_next = VERSION_WORD[0*DB +: DB];
            CTRL_VER0 + 1: rd_next = VERSION_WORD[1*DB +: DB];
            CTRL_VER0 + 2: rd_next = VERSION_WORD[2*DB +: DB];
            CTRL_VER0 + 3: rd_next = VERSION_WORD[3*DB +: DB];
            CTRL_HWID:     rd_next = data_t'(i_digital_id);
            CTRL_INFO:     rd_next = data_t'(`TESTER_IO_PHYSICAL);
            CTRL_INFO + 1: rd_next = data_t'(`TESTER_IO_LOGICAL_PER_BANK);
            CTRL_INFO + 2: rd_next = data_t'(`TESTER_IO_BANKS);
            default:       rd_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_prdata <= '0;
            reset_req_q <= 1'b0;
            o_reprogram_req <= 1'b0;
            o_reset_peripherals <= 1'b0;
        end else begin
            o_reset_peripherals <= 1'b0;
            // Bit 0 pulses the peripheral reset, bits 1 and 2 are held levels
            if (i_sel && i_penable && i_pwrite && (i_offset == CTRL_RESET)) begin
                {o_reprogram_req, reset_req_q, o_reset_peripherals} <= i_pwdata[2:0];
            end
            if (i_sel && !i_pwrite) begin
                o_prdata <= rd_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/sys_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tester_config.svh"

module sys_regs
    import tester_regs_pkg::*;
    import tester_meas_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      i_sel,
    input  logic      i_penable,
    input  logic      i_pwrite,
    input  offset_t   i_offset,
    input  data_t     i_pwdata,
    output data_t     o_prdata,
    output logic      o_pwm_enable,
    output pwm_word_t o_pwm_period,
    output pwm_word_t o_pwm_high,
    output logic      o_sample_adc,
    input  meas_t     i_mux_sync,
    input  meas_t [`TESTER_ANALOG_COUNT-1:0] i_anin_sync,
    input  samples_t  i_samples,
    input  cycles_t   i_cycles,
    input  sum_t [`TESTER_ANALOG_COUNT-1:0] i_sums
);

    localparam int DB = `TESTER_DATA_BITS;
    localparam int MEAS_BYTES = $bits(meas_t) / DB;
    localparam int SUM_BYTES = $bits(sum_t) / DB;
    // Each channel holds its measurement bytes followed by its sum
    localparam int ANIN_STRIDE = MEAS_BYTES + SUM_BYTES;

    logic wr_en;
    logic snap_pending;
    data_t rd_next;

    meas_t snap_mux;
    meas_t [`TESTER_ANALOG_COUNT-1:0] snap_anin;
    samples_t snap_samples;
    cycles_t snap_cycles;
    sum_t [`TESTER_ANALOG_COUNT-1:0] snap_sums;

    assign wr_en = i_sel && i_penable && i_pwrite;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_prdata <= '0;
            o_pwm_enable <= 1'b0;
            o_pwm_period <= '0;
            o_pwm_high <= '0;
            o_sample_adc <= 1'b0;
            snap_pending <= 1'b0;
            snap_mux <= '0;
            snap_anin <= '0;
            snap_samples <= '0;
            snap_cycles <= '0;
            snap_sums <= '0;
        end else begin
            if (snap_pending) begin
                snap_mux <= i_mux_sync;
                snap_anin <= i_anin_sync;
                snap_samples <= i_samples;
                snap_cycles <= i_cycles;
                snap_sums <= i_sums;
                snap_pending <= 1'b0;
            end
            if (wr_en) begin
                if (i_offset == SYS_PWM_EN) o_pwm_enable <= i_pwdata[0];
                if (i_offset == SYS_SNAPSHOT) snap_pending <= i_pwdata[0];
                if (i_offset == SYS_SAMPLE_ADC) o_sample_adc <= i_pwdata[0];
                for (int k = 0; k < 4; k++) begin
                    if (i_offset == offset_t'(SYS_PWM_PERIOD + k)) begin
                        o_pwm_period[k*DB +: DB] <= i_pwdata;
                    end
                    if (i_offset == offset_t'(SYS_PWM_HIGH + k)) begin
                        o_pwm_high[k*DB +: DB] <= i_pwdata;
                    end
                end
            end
            if (i_sel && !i_pwrite) begin
                o_prdata <= rd_next;
            end
        end
    end

    // Little-endian byte view of every readable register
    always_comb begin
        rd_next = '0;
        if (i_offset == SYS_PWM_EN) rd_next = data_t'(o_pwm_enable);
        if (i_offset == SYS_SAMPLE_ADC) rd_next = data_t'(o_sample_adc);
        for (int k = 0; k < 4; k++) begin
            if (i_offset == offset_t'(SYS_PWM_PERIOD + k)) rd_next = o_pwm_period[k*DB +: DB];
            if (i_offset == offset_t'(SYS_PWM_HIGH + k)) rd_next = o_pwm_high[k*DB +: DB];
            if (i_offset == offset_t'(SYS_SAMPLES + k)) rd_next = snap_samples[k*DB +: DB];
        end
        for (int k = 0; k < MEAS_BYTES; k++) begin
            if (i_offset == offset_t'(SYS_MUX_MEAS + k)) rd_next = snap_mux[k*DB +: DB];
        end
        for (int k = 0; k < 8; k++) begin
            if (i_offset == offset_t'(SYS_CYCLES + k)) rd_next = snap_cycles[k*DB +: DB];
        end
        for (int ch = 0; ch < `TESTER_ANALOG_COUNT; ch++) begin
            for (int j = 0; j < MEAS_BYTES; j++) begin
                if (i_offset == offset_t'(SYS_ANIN_BASE + ch * ANIN_STRIDE + j)) begin
                    rd_next = snap_anin[ch][j*DB +: DB];
                end
            end
            for (int j = 0; j < SUM_BYTES; j++) begin
                if (i_offset == offset_t'(SYS_ANIN_BASE + ch * ANIN_STRIDE + MEAS_BYTES + j)) begin
                    rd_next = snap_sums[ch][j*DB +: DB];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/pwm_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_generator
    import tester_meas_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      i_enable,
    input  pwm_word_t i_period,
    input  pwm_word_t i_high,
    output logic      o_pwm_val,
    output logic      o_pwm_drive
);

    pwm_word_t count;

    // Counts 0..period inclusive, so one period lasts period+1 cycles
    always_ff @(posedge clk) begin
        if (rst || !i_enable) begin
            count <= '0;
        end else if (count < i_period) begin
            count <= count + 1'b1;
        end else begin
            count <= '0;
        end
    end

    assign o_pwm_drive = i_enable;
    assign o_pwm_val = i_enable && (count < i_high);

endmodule

`default_nettype wire

// ==== src/adc_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tester_config.svh"

module adc_accumulator
    import tester_meas_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     i_sample_adc,
    input  logic [`TESTER_SAMPLE_BITS-1:0] i_mux_meas,
    input  logic     i_mux_updated,
    input  logic [`TESTER_ANALOG_COUNT*`TESTER_SAMPLE_BITS-1:0] i_anin_meas,
    input  logic [`TESTER_ANALOG_COUNT-1:0] i_anin_updated,
    output meas_t    o_mux_sync,
    output meas_t [`TESTER_ANALOG_COUNT-1:0] o_anin_sync,
    output samples_t o_samples,
    output cycles_t  o_cycles,
    output sum_t [`TESTER_ANALOG_COUNT-1:0] o_sums
);

    localparam int SB = `TESTER_SAMPLE_BITS;
    // One sequence is the mux channel plus every ANIN channel
    localparam int SEQ_LEN = `TESTER_ANALOG_COUNT + 1;
    localparam int CONV_BITS = $clog2(SEQ_LEN + 1);

    logic any_update;
    logic [CONV_BITS-1:0] conv_count;
    logic [CONV_BITS-1:0] conv_next;

    meas_t mux_meas;
    meas_t [`TESTER_ANALOG_COUNT-1:0] anin_meas;

    assign any_update = i_mux_updated || (|i_anin_updated);
    assign conv_next = conv_count + CONV_BITS'(any_update);

    always_ff @(posedge clk) begin
        if (rst) begin
            conv_count <= '0;
            mux_meas <= '0;
            anin_meas <= '0;
            o_mux_sync <= '0;
            o_anin_sync <= '0;
            o_samples <= '0;
            o_cycles <= '0;
            o_sums <= '0;
        end else if (i_sample_adc) begin
            o_cycles <= o_cycles + 1'b1;
            if (i_mux_updated) begin
                mux_meas <= meas_t'(i_mux_meas);
            end
            for (int i = 0; i < `TESTER_ANALOG_COUNT; i++) begin
                if (i_anin_updated[i]) begin
                    anin_meas[i] <= meas_t'(i_anin_meas[i*SB +: SB]);
                    o_sums[i] <= o_sums[i] + sum_t'(i_anin_meas[i*SB +: SB]);
                end
            end
            // End of a sequence, sync copies take the values stored before this cycle
            if (conv_next == CONV_BITS'(SEQ_LEN)) begin
                conv_count <= '0;
                o_samples <= o_samples + 1'b1;
                o_mux_sync <= mux_meas;
                o_anin_sync <= anin_meas;
            end else begin
                conv_count <= conv_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/mbed_tester_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tester_config.svh"

module mbed_tester_top
    import tester_regs_pkg::*;
    import tester_meas_pkg::*;
(
    input  logic clk,
    input  logic rst,

    input  logic  i_psel,
    input  logic  i_penable,
    input  logic  i_pwrite,
    input  addr_t i_paddr,
    input  data_t i_pwdata,
    output data_t o_prdata,

    input  logic i_reset_btn_n,
    input  logic [`TESTER_DIGITAL_ID_COUNT-1:0] i_digital_id,

    output logic o_reset_req,
    output logic o_reprogram_req,
    output logic o_reset_peripherals,
    output logic o_pwm_val,
    output logic o_pwm_drive,
    output logic o_sample_adc,

    input  logic [`TESTER_SAMPLE_BITS-1:0] i_mux_meas,
    input  logic i_mux_updated,
    input  logic [`TESTER_ANALOG_COUNT*`TESTER_SAMPLE_BITS-1:0] i_anin_meas,
    input  logic [`TESTER_ANALOG_COUNT-1:0] i_anin_updated
);

    blk_sel_e blk;
    offset_t offset;

    logic ctrl_sel;
    logic sys_sel;
    data_t ctrl_prdata;
    data_t sys_prdata;

    logic pwm_enable;
    pwm_word_t pwm_period;
    pwm_word_t pwm_high;

    meas_t mux_sync;
    meas_t [`TESTER_ANALOG_COUNT-1:0] anin_sync;
    samples_t samples;
    cycles_t cycles;
    sum_t [`TESTER_ANALOG_COUNT-1:0] sums;

    assign blk = blk_sel_e'(i_paddr[`TESTER_ADDR_BITS-1:`TESTER_OFFSET_BITS]);
    assign offset = i_paddr[`TESTER_OFFSET_BITS-1:0];

    apb_block_decode u_decode (
        .i_psel(i_psel),
        .i_blk(blk),
        .i_ctrl_prdata(ctrl_prdata),
        .i_sys_prdata(sys_prdata),
        .o_ctrl_sel(ctrl_sel),
        .o_sys_sel(sys_sel),
        .o_prdata(o_prdata)
    );

    tester_control_regs u_control (
        .clk(clk),
        .rst(rst),
        .i_sel(ctrl_sel),
        .i_penable(i_penable),
        .i_pwrite(i_pwrite),
        .i_offset(offset),
        .i_pwdata(i_pwdata),
        .i_reset_btn_n(i_reset_btn_n),
        .i_digital_id(i_digital_id),
        .o_prdata(ctrl_prdata),
        .o_reset_req(o_reset_req),
        .o_reprogram_req(o_reprogram_req),
        .o_reset_peripherals(o_reset_peripherals)
    );

    sys_regs u_sys (
        .clk(clk),
        .rst(rst),
        .i_sel(sys_sel),
        .i_penable(i_penable),
        .i_pwrite(i_pwrite),
        .i_offset(offset),
        .i_pwdata(i_pwdata),
        .o_prdata(sys_prdata),
        .o_pwm_enable(pwm_enable),
        .o_pwm_period(pwm_period),
        .o_pwm_high(pwm_high),
        .o_sample_adc(o_sample_adc),
        .i_mux_sync(mux_sync),
        .i_anin_sync(anin_sync),
        .i_samples(samples),
        .i_cycles(cycles),
        .i_sums(sums)
    );

    pwm_generator u_pwm (
        .clk(clk),
        .rst(rst),
        .i_enable(pwm_enable),
        .i_period(pwm_period),
        .i_high(pwm_high),
        .o_pwm_val(o_pwm_val),
        .o_pwm_drive(o_pwm_drive)
    );

    adc_accumulator u_adc (
        .clk(clk),
        .rst(rst),
        .i_sample_adc(o_sample_adc),
        .i_mux_meas(i_mux_meas),
        .i_mux_updated(i_mux_updated),
        .i_anin_meas(i_anin_meas),
        .i_anin_updated(i_anin_updated),
        .o_mux_sync(mux_sync),
        .o_anin_sync(anin_sync),
        .o_samples(samples),
        .o_cycles(cycles),
        .o_sums(sums)
    );

endmodule

`default_nettype wire

// ==== tb/tb_mbed_tester.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tester_config.svh"

module tb_mbed_tester
    import tester_regs_pkg::*;
    import tester_meas_pkg::*;
();

    localparam int CHANNELS = `TESTER_ANALOG_COUNT;
    localparam int SB = `TESTER_SAMPLE_BITS;
    localparam int SAMPLE_CYCLES = 200;
    localparam int PWM_PERIODS = 3;
    localparam int ANIN_STRIDE = 10;
    // Under 1000 cycles are needed, so this leaves a wide margin
    localparam int MAX_CYCLES = 20000;

    logic clk;
    logic rst;
    logic i_psel;
    logic i_penable;
    logic i_pwrite;
    addr_t i_paddr;
    data_t i_pwdata;
    data_t o_prdata;
    logic i_reset_btn_n;
    logic [`TESTER_DIGITAL_ID_COUNT-1:0] i_digital_id;
    logic o_reset_req;
    logic o_reprogram_req;
    logic o_reset_peripherals;
    logic o_pwm_val;
    logic o_pwm_drive;
    logic o_sample_adc;
    logic [SB-1:0] i_mux_meas;
    logic i_mux_updated;
    logic [CHANNELS*SB-1:0] i_anin_meas;
    logic [CHANNELS-1:0] i_anin_updated;

    integer seed;
    int errors;
    int checks;
    int test_start_errors;
    int cycle_count;

    // Accumulator model state
    logic [15:0] m_meas_mux;
    logic [15:0] m_sync_mux;
    logic [15:0] m_meas_anin [CHANNELS];
    logic [15:0] m_sync_anin [CHANNELS];
    logic [63:0] m_sums [CHANNELS];
    logic [31:0] m_samples;
    int m_conv;

    logic [31:0] rnd;
    logic [31:0] period;
    logic [31:0] high;
    logic [63:0] word;
    data_t rd;
    data_t en_byte;
    logic [11:0] off;
    int sel;
    int high_count;
    int pulse_count;
    logic mux_upd;
    logic [SB-1:0] mux_val;
    logic [CHANNELS-1:0] anin_upd;
    logic [CHANNELS*SB-1:0] anin_val;

    mbed_tester_top i_mbed_tester_top (
        .clk(clk),
        .rst(rst),
        .i_psel(i_psel),
        .i_penable(i_penable),
        .i_pwrite(i_pwrite),
        .i_paddr(i_paddr),
        .i_pwdata(i_pwdata),
        .o_prdata(o_prdata),
        .i_reset_btn_n(i_reset_btn_n),
        .i_digital_id(i_digital_id),
        .o_reset_req(o_reset_req),
        .o_reprogram_req(o_reprogram_req),
        .o_reset_peripherals(o_reset_peripherals),
        .o_pwm_val(o_pwm_val),
        .o_pwm_drive(o_pwm_drive),
        .o_sample_adc(o_sample_adc),
        .i_mux_meas(i_mux_meas),
        .i_mux_updated(i_mux_updated),
        .i_anin_meas(i_anin_meas),
        .i_anin_updated(i_anin_updated)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic addr_t ctrl_addr(input offset_t o);
        return {2'b00, o};
    endfunction

    function automatic addr_t sys_addr(input offset_t o);
        return {2'b10, o};
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
            input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    // Setup cycle, access cycle, then idle
    task automatic write_reg(input addr_t addr, input data_t data);
        @(posedge clk);
        i_psel <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite <= 1'b1;
        i_paddr <= addr;
        i_pwdata <= data;
        @(posedge clk);
        i_penable <= 1'b1;
        @(posedge clk);
        i_psel <= 1'b0;
        i_penable <= 1'b0;
    endtask

    task automatic read_reg(input addr_t addr, output data_t data);
        @(posedge clk);
        i_psel <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite <= 1'b0;
        i_paddr <= addr;
        @(posedge clk);
        i_penable <= 1'b1;
        // Read byte is settled by the middle of the access cycle
        @(negedge clk);
        data = o_prdata;
        @(posedge clk);
        i_psel <= 1'b0;
        i_penable <= 1'b0;
    endtask

    // Little-endian multi-byte read from the system block
    task automatic read_word(input int base, input int nbytes, output logic [63:0] value);
        data_t b;
        value = '0;
        for (int k = 0; k < nbytes; k++) begin
            read_reg(sys_addr(offset_t'(base + k)), b);
            value[k*8 +: 8] = b;
        end
    endtask

    task automatic model_conversion(input logic mux_u, input logic [SB-1:0] mux_v,
            input logic [CHANNELS-1:0] upd, input logic [CHANNELS*SB-1:0] anin_v);
        int c;
        if (mux_u || (upd != '0)) begin
            m_conv = m_conv + 1;
            // A full sequence publishes what was stored before this conversion
            if (m_conv == CHANNELS + 1) begin
                m_conv = 0;
                m_samples = m_samples + 1;
                m_sync_mux = m_meas_mux;
                for (c = 0; c < CHANNELS; c++) begin
                    m_sync_anin[c] = m_meas_anin[c];
                end
            end
        end
        if (mux_u) begin
            m_meas_mux = {4'h0, mux_v};
        end
        for (c = 0; c < CHANNELS; c++) begin
            if (upd[c]) begin
                m_meas_anin[c] = {4'h0, anin_v[c*SB +: SB]};
                m_sums[c] = m_sums[c] + {52'h0, anin_v[c*SB +: SB]};
            end
        end
    endtask

    initial begin
        seed = 32'hdc53_769f;
        errors = 0;
        checks = 0;
        test_start_errors = 0;
        cycle_count = 0;
        m_meas_mux = '0;
        m_sync_mux = '0;
        m_samples = '0;
        m_conv = 0;
        for (int c = 0; c < CHANNELS; c++) begin
            m_meas_anin[c] = '0;
            m_sync_anin[c] = '0;
            m_sums[c] = '0;
        end
        rnd = $random(seed);
        rst <= 1'b1;
        i_psel <= 1'b0;
        i_penable <= 1'b0;
        i_pwrite <= 1'b0;
        i_paddr <= '0;
        i_pwdata <= '0;
        i_reset_btn_n <= 1'b1;
        i_digital_id <= rnd[2:0];
        i_mux_meas <= '0;
        i_mux_updated <= 1'b0;
        i_anin_meas <= '0;
        i_anin_updated <= '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // Test 1: idle outputs and read-only control space
        @(negedge clk);
        check_value("reset_req after reset", o_reset_req, 0);
        check_value("reprogram_req after reset", o_reprogram_req, 0);
        check_value("reset_peripherals after reset", o_reset_peripherals, 0);
        check_value("pwm_drive after reset", o_pwm_drive, 0);
        check_value("sample_adc after reset", o_sample_adc, 0);
        read_reg(ctrl_addr(12'h000), rd);
        check_value("id byte 0", rd, "m");
        read_reg(ctrl_addr(12'h001), rd);
        check_value("id byte 1", rd, "b");
        read_reg(ctrl_addr(12'h002), rd);
        check_value("id byte 2", rd, "e");
        read_reg(ctrl_addr(12'h003), rd);
        check_value("id byte 3", rd, "d");
        for (int k = 0; k < 4; k++) begin
            read_reg(ctrl_addr(offset_t'(12'h010 + k)), rd);
            check_value("version byte", rd, (k == 0) ? 8'h01 : 8'h00);
        end
        read_reg(ctrl_addr(12'h014), rd);
        check_value("hardware id", rd, {5'b0, rnd[2:0]});
        read_reg(ctrl_addr(12'h020), rd);
        check_value("physical io count", rd, 16);
        read_reg(ctrl_addr(12'h021), rd);
        check_value("logical io per bank", rd, 8);
        read_reg(ctrl_addr(12'h022), rd);
        check_value("bank count", rd, 2);
        for (int k = 0; k < 4; k++) begin
            rnd = $random(seed);
            read_reg({rnd[13] ? 2'b11 : 2'b01, rnd[11:0]}, rd);
            check_value("unmapped block read", rd, 0);
            off = rnd[27:16] | 12'h100;
            read_reg(ctrl_addr(off), rd);
            check_value("unmapped control offset read", rd, 0);
        end
        end_test(1, "identity and idle state");

        // Test 2: reset register and button
        write_reg(ctrl_addr(12'h000), 8'h01);
        pulse_count = 0;
        repeat (6) begin
            @(negedge clk);
            if (o_reset_peripherals) pulse_count++;
        end
        check_value("reset_peripherals pulse length", pulse_count, 1);
        check_value("reset_req after pulse write", o_reset_req, 0);
        write_reg(ctrl_addr(12'h000), 8'h06);
        @(negedge clk);
        check_value("reset_req set", o_reset_req, 1);
        check_value("reprogram_req set", o_reprogram_req, 1);
        check_value("no pulse without bit 0", o_reset_peripherals, 0);
        write_reg(ctrl_addr(12'h000), 8'h00);
        @(negedge clk);
        check_value("reset_req cleared", o_reset_req, 0);
        check_value("reprogram_req cleared", o_reprogram_req, 0);
        @(posedge clk);
        i_reset_btn_n <= 1'b0;
        @(negedge clk);
        check_value("reset_req from button", o_reset_req, 1);
        @(posedge clk);
        i_reset_btn_n <= 1'b1;
        @(negedge clk);
        check_value("reset_req button released", o_reset_req, 0);
        end_test(2, "reset requests");

        // Test 3: PWM register readback
        period = $random(seed);
        high = $random(seed);
        rnd = $random(seed);
        en_byte = rnd[7:0];
        for (int k = 0; k < 4; k++) begin
            write_reg(sys_addr(offset_t'(SYS_PWM_PERIOD + k)), period[k*8 +: 8]);
            write_reg(sys_addr(offset_t'(SYS_PWM_HIGH + k)), high[k*8 +: 8]);
        end
        write_reg(sys_addr(SYS_PWM_EN), en_byte);
        read_word(SYS_PWM_PERIOD, 4, word);
        check_value("pwm period readback", word, {32'h0, period});
        read_word(SYS_PWM_HIGH, 4, word);
        check_value("pwm high readback", word, {32'h0, high});
        read_reg(sys_addr(SYS_PWM_EN), rd);
        // Enable is a single bit
        check_value("pwm enable readback", rd, {7'h0, en_byte[0]});
        end_test(3, "pwm registers");

        // Test 4: PWM waveform
        write_reg(sys_addr(SYS_PWM_EN), 8'h00);
        period = $unsigned($random(seed)) % 41;
        high = $unsigned($random(seed)) % (period + 2);
        for (int k = 0; k < 4; k++) begin
            write_reg(sys_addr(offset_t'(SYS_PWM_PERIOD + k)), period[k*8 +: 8]);
            write_reg(sys_addr(offset_t'(SYS_PWM_HIGH + k)), high[k*8 +: 8]);
        end
        write_reg(sys_addr(SYS_PWM_EN), 8'h01);
        high_count = 0;
        repeat (PWM_PERIODS * (period + 1)) begin
            @(negedge clk);
            check_value("pwm drive while enabled", o_pwm_drive, 1);
            if (o_pwm_val) high_count++;
        end
        check_value("pwm high cycles", high_count, PWM_PERIODS * high);
        write_reg(sys_addr(SYS_PWM_EN), 8'h00);
        @(negedge clk);
        check_value("pwm drive disabled", o_pwm_drive, 0);
        check_value("pwm val disabled", o_pwm_val, 0);
        end_test(4, "pwm generator");

        // Test 5: ADC accumulation and snapshot
        write_reg(sys_addr(SYS_SAMPLE_ADC), 8'h01);
        @(negedge clk);
        check_value("sample_adc enabled", o_sample_adc, 1);
        for (int i = 0; i < SAMPLE_CYCLES; i++) begin
            @(posedge clk);
            sel = $unsigned($random(seed)) % 8;
            rnd = $random(seed);
            mux_val = rnd[11:0];
            mux_upd = (sel == CHANNELS);
            anin_upd = '0;
            if (sel < CHANNELS) anin_upd[sel] = 1'b1;
            for (int c = 0; c < CHANNELS; c++) begin
                rnd = $random(seed);
                anin_val[c*SB +: SB] = rnd[11:0];
            end
            i_mux_meas <= mux_val;
            i_mux_updated <= mux_upd;
            i_anin_meas <= anin_val;
            i_anin_updated <= anin_upd;
            model_conversion(mux_upd, mux_val, anin_upd, anin_val);
        end
        @(posedge clk);
        i_mux_updated <= 1'b0;
        i_anin_updated <= '0;
        write_reg(sys_addr(SYS_SAMPLE_ADC), 8'h00);
        @(negedge clk);
        check_value("sample_adc disabled", o_sample_adc, 0);
        write_reg(sys_addr(SYS_SNAPSHOT), 8'h01);
        read_word(SYS_MUX_MEAS, 2, word);
        check_value("mux sync measurement", word, {48'h0, m_sync_mux});
        read_word(SYS_SAMPLES, 4, word);
        check_value("sample count", word, {32'h0, m_samples});
        // Loop edges, the strobe-clear edge and the three edges of the disable write
        read_word(SYS_CYCLES, 8, word);
        check_value("power cycle count", word, SAMPLE_CYCLES + 4);
        for (int c = 0; c < CHANNELS; c++) begin
            read_word(SYS_ANIN_BASE + c * ANIN_STRIDE, 2, word);
            check_value("anin sync measurement", word, {48'h0, m_sync_anin[c]});
            read_word(SYS_ANIN_BASE + c * ANIN_STRIDE + 2, 8, word);
            check_value("anin sum", word, m_sums[c]);
        end
        end_test(5, "adc accumulator");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+src
src/tester_regs_pkg.sv
src/tester_meas_pkg.sv
src/apb_block_decode.sv
src/tester_control_regs.sv
src/sys_regs.sv
src/pwm_generator.sv
src/adc_accumulator.sv
src/mbed_tester_top.sv
tb/tb_mbed_tester.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator, result decided from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f \
    --top-module tb_mbed_tester --Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
